//--- common/gdiv_pkg.sv
// Shared definitions for the Goldschmidt mantissa divider
// Default widths and seed table size
// Iteration count and fixed latency helpers
// Control state and multiplier operand encodings

package gdiv_pkg;

   // Default mantissa width with the hidden bit included
   localparam int MANT_W_DEF = 24;

   // Divisor bits that index the seed table, also the seed accuracy in bits
   localparam int SEED_BITS = 8;

   // Accuracy doubles per pass, stop once it is past mant_w+2 bits
   function automatic int gdiv_iters(input int mant_w);
      int acc;
      int iters;
      acc = SEED_BITS;
      iters = 0;
      while (acc <= mant_w + 2) begin
         acc = acc * 2;
         iters = iters + 1;
      end
      return iters;
   endfunction

   // Cycles from the start edge to done
   // Seed pair, four per iteration, remainder pass and correction
   function automatic int gdiv_latency(input int mant_w);
      return 4 * gdiv_iters(mant_w) + 6;
   endfunction

   // Sequencer states
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_SEED,
      ST_ITER_MUL_D,
      ST_ITER_MUL_N,
      ST_ITER_WAIT,
      ST_REM_MUL,
      ST_REM_WAIT,
      ST_CORRECT
   } gdiv_state_e;

   // Multiplier operand sources
   typedef enum logic [2:0] {
      SEL_DIVISOR,
      SEL_DIVIDEND,
      SEL_SEED,
      SEL_RECIP,
      SEL_NUM,
      SEL_DEN,
      SEL_QUOT
   } opnd_sel_e;

endpackage

//--- hw/gdiv/recip_seed.sv
`timescale 1ns/1ns
// Reciprocal seed table for the divider
// One entry per divisor interval in [1,2), rounded reciprocal of the midpoint
// Combinational lookup

module recip_seed #(
   parameter int SEED_BITS = gdiv_pkg::SEED_BITS
) (
   input  logic [SEED_BITS-2:0] d_msbs,
   output logic [SEED_BITS:0]   seed
);

   localparam int ENTRIES = 2 ** (SEED_BITS - 1);
   localparam int SEED_W  = SEED_BITS + 1;

   // Seed is 0.xxxxxxxxx, so values sit in [0.5,1)
   // Midpoint of interval idx is (2^S + 2*idx + 1) / 2^S
   function automatic logic [SEED_BITS:0] seed_entry(input int idx);
      longint num;
      longint den;
      // Twice the scaled reciprocal, halved after adding one to round
      num = longint'(1) << (2 * SEED_BITS + 2);
      den = (longint'(1) << SEED_BITS) + 2 * idx + 1;
      return SEED_W'(((num / den) + 1) >> 1);
   endfunction

   logic [SEED_BITS:0] seed_rom [ENTRIES];

   // Table contents are constants built at elaboration
   for (genvar i = 0; i < ENTRIES; i++) begin : g_entry
      assign seed_rom[i] = seed_entry(i);
   end

   assign seed = seed_rom[d_msbs];

   // Every entry is a normalized reciprocal
   // Divisor is unknown until the first capture
   always_comb begin
      a_seed_norm: assert (seed[SEED_BITS] !== 1'b0)
         else $error("seed 0x%0h lacks its leading bit", seed);
   end

endmodule

//--- hw/gdiv/gdiv_conv_pipe.sv
`timescale 1ns/1ns
// Goldschmidt convergence datapath
// Operand capture and two operand multiplexers
// Single multiplier with a two stage pipe and travelling destination tags
// Running num, den and 2-den registers
// Remainder of the truncated quotient

module gdiv_conv_pipe #(
   parameter int MANT_W = gdiv_pkg::MANT_W_DEF
) (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            capture,
   input  logic [MANT_W-1:0]               n,
   input  logic [MANT_W-1:0]               d,
   input  logic [gdiv_pkg::SEED_BITS:0]    seed,
   input  gdiv_pkg::opnd_sel_e             sel_a,
   input  gdiv_pkg::opnd_sel_e             sel_b,
   input  logic                            issue,
   input  logic                            load_num,
   input  logic                            load_den,
   input  logic                            load_recip,
   input  logic                            load_rem,
   output logic [gdiv_pkg::SEED_BITS-2:0]  d_msbs,
   output logic [MANT_W-1:0]               d_hold,
   output logic [MANT_W:0]                 q_trunc,
   output logic signed [MANT_W+1:0]        rem
);

   import gdiv_pkg::*;

   // Fixed point with FW fraction bits and two integer bits
   localparam int FW = MANT_W + 4;
   localparam int XW = FW + 2;
   localparam int PW = 2 * XW;
   // Alignment of quotient, mantissa and seed into the fraction
   localparam int SH_Q = FW - MANT_W;
   localparam int SH_D = FW - MANT_W + 1;
   localparam int SH_S = FW - SEED_BITS - 1;

   logic [MANT_W-1:0]        n_cap;
   logic [MANT_W-1:0]        d_cap;
   logic [XW-1:0]            opnd_a;
   logic [XW-1:0]            opnd_b;
   logic [PW-1:0]            prod;
   logic [PW-1:0]            prod_s1;
   logic                     s1_num;
   logic                     s1_den;
   logic                     s1_recip;
   logic                     s1_rem;
   logic [XW-1:0]            prod_fix;
   logic [PW-1:0]            n_scaled;
   logic [PW-1:0]            rem_diff;
   logic [XW-1:0]            num_q;
   logic [XW-1:0]            den_q;
   logic [XW-1:0]            recip_q;
   logic signed [MANT_W+1:0] rem_q;
   logic [MANT_W+1:0]        rem_mag;

   // Operands held for the whole operation
   always_ff @(posedge clk) begin
      if (capture) begin
         n_cap <= n;
         d_cap <= d;
      end
   end

   assign d_msbs = d_cap[MANT_W-2 -: SEED_BITS-1];
   assign d_hold = d_cap;
   // Quotient keeps MANT_W fraction bits of num
   assign q_trunc = num_q[SH_Q +: MANT_W+1];

   ////////////////////////////////////////
   // Operand select and multiply
   ////////////////////////////////////////

   // Mantissas are 1.xxx, seed is 0.xxx, quotient is x.xxx
   function automatic logic [XW-1:0] opnd_mux(input opnd_sel_e sel);
      case (sel)
         SEL_DIVISOR:  opnd_mux = XW'({d_cap, {SH_D{1'b0}}});
         SEL_DIVIDEND: opnd_mux = XW'({n_cap, {SH_D{1'b0}}});
         SEL_SEED:     opnd_mux = XW'({seed, {SH_S{1'b0}}});
         SEL_RECIP:    opnd_mux = recip_q;
         SEL_NUM:      opnd_mux = num_q;
         SEL_DEN:      opnd_mux = den_q;
         SEL_QUOT:     opnd_mux = XW'({q_trunc, {SH_Q{1'b0}}});
         default:      opnd_mux = '0;
      endcase
   endfunction

   always_comb begin
      opnd_a = opnd_mux(sel_a);
      opnd_b = opnd_mux(sel_b);
   end

   assign prod = PW'(opnd_a) * PW'(opnd_b);

   // Stage 1, product plus the tags naming its destination
   always_ff @(posedge clk) begin
      if (reset) begin
         s1_num   <= 1'b0;
         s1_den   <= 1'b0;
         s1_recip <= 1'b0;
         s1_rem   <= 1'b0;
      end else begin
         s1_num   <= issue & load_num;
         s1_den   <= issue & load_den;
         s1_recip <= issue & load_recip;
         s1_rem   <= issue & load_rem;
      end
   end

   always_ff @(posedge clk) begin
      if (issue) begin
         prod_s1 <= prod;
      end
   end

   ////////////////////////////////////////
   // Stage 2 write back
   ////////////////////////////////////////

   // Product realigned to FW fraction bits, truncated
   assign prod_fix = prod_s1[FW +: XW];

   // Remainder pass multiplies q << SH_Q by d << SH_D, so scale n to match
   assign n_scaled = PW'({n_cap, {(MANT_W + SH_Q + SH_D){1'b0}}});
   assign rem_diff = n_scaled - prod_s1;

   always_ff @(posedge clk) begin
      if (s1_num) begin
         num_q <= prod_fix;
      end
      if (s1_den) begin
         den_q <= prod_fix;
      end
      // 2-den by one's complement, one ulp low, den stays below 2
      if (s1_recip) begin
         recip_q <= {1'b0, ~prod_fix[XW-2:0]};
      end
      if (s1_rem) begin
         rem_q <= rem_diff[SH_Q + SH_D +: MANT_W + 2];
      end
   end

   assign rem = rem_q;

   // Converged quotient lands within one step of the true one
   assign rem_mag = rem_q[MANT_W+1] ? -rem_q : rem_q;

   a_rem_bound: assert property (@(posedge clk) disable iff (reset)
      s1_rem |=> (rem_mag < {1'b0, d_cap, 1'b0}))
      else $error("remainder 0x%0h out of range for d 0x%0h", rem_q, d_cap);

endmodule

//--- hw/gdiv/gdiv_control.sv
`timescale 1ns/1ns
// Sequencer for the Goldschmidt divider
// Seed products, convergence iterations, remainder pass and correction
// Drives operand selects, destination tags, busy and the done strobe

module gdiv_control #(
   parameter int MANT_W = gdiv_pkg::MANT_W_DEF
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                start,
   output logic                busy,
   output logic                done,
   output logic                capture,
   output logic                issue,
   output gdiv_pkg::opnd_sel_e sel_a,
   output gdiv_pkg::opnd_sel_e sel_b,
   output logic                load_num,
   output logic                load_den,
   output logic                load_recip,
   output logic                load_rem,
   output logic                correct_en
);

   import gdiv_pkg::*;

   localparam int ITERS   = gdiv_iters(MANT_W);
   localparam int LATENCY = gdiv_latency(MANT_W);
   localparam int CNT_W   = $clog2(ITERS + 1);

   gdiv_state_e      state_q;
   gdiv_state_e      state_d;
   logic             phase_q;
   logic             phase_d;
   logic [CNT_W-1:0] iter_q;
   logic [CNT_W-1:0] iter_d;
   logic             last_iter;

   // Busy covers the done cycle, a start there is dropped
   assign busy       = (state_q != ST_IDLE) | done;
   assign capture    = start & ~busy;
   assign last_iter  = (iter_q == CNT_W'(ITERS - 1));
   assign correct_en = (state_q == ST_CORRECT);

   ////////////////////////////////////////
   // Next state
   ////////////////////////////////////////

   // Seed and wait states span two cycles, phase picks the half
   always_comb begin
      state_d = state_q;
      phase_d = phase_q;
      iter_d  = iter_q;
      case (state_q)
         ST_IDLE: begin
            if (capture) begin
               state_d = ST_SEED;
               phase_d = 1'b0;
            end
         end
         ST_SEED: begin
            phase_d = ~phase_q;
            if (phase_q) begin
               state_d = ST_ITER_MUL_D;
               iter_d  = '0;
            end
         end
         ST_ITER_MUL_D: state_d = ST_ITER_MUL_N;
         ST_ITER_MUL_N: state_d = ST_ITER_WAIT;
         ST_ITER_WAIT: begin
            phase_d = ~phase_q;
            // Second wait cycle lets the new num settle before the next pass
            if (phase_q) begin
               if (last_iter) begin
                  state_d = ST_REM_MUL;
               end else begin
                  state_d = ST_ITER_MUL_D;
                  iter_d  = iter_q + CNT_W'(1);
               end
            end
         end
         ST_REM_MUL:  state_d = ST_REM_WAIT;
         ST_REM_WAIT: state_d = ST_CORRECT;
         ST_CORRECT:  state_d = ST_IDLE;
         default:     state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state_q <= ST_IDLE;
         phase_q <= 1'b0;
         iter_q  <= '0;
         done    <= 1'b0;
      end else begin
         state_q <= state_d;
         phase_q <= phase_d;
         iter_q  <= iter_d;
         // Lines up with the result registers in the correction stage
         done    <= correct_en;
      end
   end

   ////////////////////////////////////////
   // Multiplier issue decode
   ////////////////////////////////////////

   always_comb begin
      issue      = 1'b0;
      sel_a      = SEL_DIVISOR;
      sel_b      = SEL_DIVISOR;
      load_num   = 1'b0;
      load_den   = 1'b0;
      load_recip = 1'b0;
      load_rem   = 1'b0;
      case (state_q)
         ST_SEED: begin
            issue = 1'b1;
            sel_b = SEL_SEED;
            // d*seed first, then n*seed
            if (!phase_q) begin
               sel_a      = SEL_DIVISOR;
               load_den   = 1'b1;
               load_recip = 1'b1;
            end else begin
               sel_a    = SEL_DIVIDEND;
               load_num = 1'b1;
            end
         end
         ST_ITER_MUL_D: begin
            issue      = 1'b1;
            sel_a      = SEL_DEN;
            sel_b      = SEL_RECIP;
            load_den   = 1'b1;
            load_recip = 1'b1;
         end
         ST_ITER_MUL_N: begin
            // Still reads the previous 2-den, its update lands a cycle later
            issue    = 1'b1;
            sel_a    = SEL_NUM;
            sel_b    = SEL_RECIP;
            load_num = 1'b1;
         end
         ST_REM_MUL: begin
            issue    = 1'b1;
            sel_a    = SEL_QUOT;
            sel_b    = SEL_DIVISOR;
            load_rem = 1'b1;
         end
         default: begin
            issue = 1'b0;
         end
      endcase
   end

   a_done_pulse: assert property (@(posedge clk) disable iff (reset)
      done |=> !done)
      else $error("done held for two cycles");

   a_idle_quiet: assert property (@(posedge clk) disable iff (reset)
      (state_q == ST_IDLE) |-> !issue)
      else $error("multiply issued while idle");

   // Fixed latency from the accepted start to done
   a_latency: assert property (@(posedge clk) disable iff (reset)
      capture |-> ##LATENCY done)
      else $error("done missed its fixed latency");

endmodule

//--- hw/gdiv/gdiv_correct.sv
`timescale 1ns/1ns
// Quotient correction for the divider
// Picks q-1, q or q+1 from the remainder of the truncated quotient
// Registers the quotient and the exact flag

module gdiv_correct #(
   parameter int MANT_W = gdiv_pkg::MANT_W_DEF
) (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     correct_en,
   input  logic [MANT_W:0]          q_trunc,
   input  logic signed [MANT_W+1:0] rem,
   input  logic [MANT_W-1:0]        d,
   output logic [MANT_W:0]          quot,
   output logic                     exact
);

   logic signed [MANT_W+1:0] d_ext;
   logic [MANT_W:0]          q_sel;
   logic signed [MANT_W+1:0] rem_sel;

   assign d_ext = {2'b00, d};

   // Remainder of the chosen quotient ends up in [0, d)
   always_comb begin
      if (rem[MANT_W+1]) begin
         // Overshoot by one
         q_sel   = q_trunc - {{MANT_W{1'b0}}, 1'b1};
         rem_sel = rem + d_ext;
      end else if (rem >= d_ext) begin
         // Undershoot by one
         q_sel   = q_trunc + {{MANT_W{1'b0}}, 1'b1};
         rem_sel = rem - d_ext;
      end else begin
         q_sel   = q_trunc;
         rem_sel = rem;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         quot  <= '0;
         exact <= 1'b0;
      end else if (correct_en) begin
         quot  <= q_sel;
         exact <= (rem_sel == '0);
      end
   end

   // Datapath error stays within one quotient step
   a_rem_window: assert property (@(posedge clk) disable iff (reset)
      correct_en |-> ((rem >= -d_ext) && (rem < (d_ext <<< 1))))
      else $error("remainder 0x%0h outside [-d, 2d) for d 0x%0h", rem, d);

endmodule

//--- hw/gdiv_top.sv
`timescale 1ns/1ns
// Goldschmidt mantissa divider top level
// Sequencer, reciprocal seed table, convergence datapath and correction stage

module gdiv_top #(
   parameter int MANT_W = gdiv_pkg::MANT_W_DEF
) (
   input  logic              clk,
   input  logic              reset,
   input  logic              start,
   input  logic [MANT_W-1:0] n,
   input  logic [MANT_W-1:0] d,
   output logic              busy,
   output logic              done,
   output logic [MANT_W:0]   quot,
   output logic              exact
);

   import gdiv_pkg::*;

   // Sequencer to datapath
   logic      capture;
   logic      issue;
   opnd_sel_e sel_a;
   opnd_sel_e sel_b;
   logic      load_num;
   logic      load_den;
   logic      load_recip;
   logic      load_rem;
   logic      correct_en;

   // Seed lookup
   logic [SEED_BITS-2:0] d_msbs;
   logic [SEED_BITS:0]   seed;

   // Datapath to correction
   logic [MANT_W-1:0]        d_hold;
   logic [MANT_W:0]          q_trunc;
   logic signed [MANT_W+1:0] rem;

   gdiv_control #(
      .MANT_W (MANT_W)
   ) u_control (
      .clk        (clk),
      .reset      (reset),
      .start      (start),
      .busy       (busy),
      .done       (done),
      .capture    (capture),
      .issue      (issue),
      .sel_a      (sel_a),
      .sel_b      (sel_b),
      .load_num   (load_num),
      .load_den   (load_den),
      .load_recip (load_recip),
      .load_rem   (load_rem),
      .correct_en (correct_en)
   );

   recip_seed #(
      .SEED_BITS (SEED_BITS)
   ) u_seed (
      .d_msbs (d_msbs),
      .seed   (seed)
   );

   gdiv_conv_pipe #(
      .MANT_W (MANT_W)
   ) u_conv (
      .clk        (clk),
      .reset      (reset),
      .capture    (capture),
      .n          (n),
      .d          (d),
      .seed       (seed),
      .sel_a      (sel_a),
      .sel_b      (sel_b),
      .issue      (issue),
      .load_num   (load_num),
      .load_den   (load_den),
      .load_recip (load_recip),
      .load_rem   (load_rem),
      .d_msbs     (d_msbs),
      .d_hold     (d_hold),
      .q_trunc    (q_trunc),
      .rem        (rem)
   );

   gdiv_correct #(
      .MANT_W (MANT_W)
   ) u_correct (
      .clk        (clk),
      .reset      (reset),
      .correct_en (correct_en),
      .q_trunc    (q_trunc),
      .rem        (rem),
      .d          (d_hold),
      .quot       (quot),
      .exact      (exact)
   );

endmodule

//--- bench/gdiv_tb.sv
`timescale 1ns/1ns
// Testbench for the Goldschmidt mantissa divider
// Clock and reset generation
// Directed vector table and seeded random vectors
// Compare tasks for quotient, flags and latency
// Watchdog on the total run time

module gdiv_tb;

   import gdiv_pkg::*;

   localparam int MANT_W  = MANT_W_DEF;
   localparam int LATENCY = gdiv_latency(MANT_W);
   localparam int N_RAND  = 200;
   // Upper bound on table entries, used only for the watchdog budget
   localparam int N_DIR   = 24;
   localparam longint WATCHDOG_NS = longint'(N_DIR + N_RAND + 4) * (LATENCY + 4) * 20 + 5000;

   logic              clk;
   logic              reset;
   logic              start;
   logic [MANT_W-1:0] n;
   logic [MANT_W-1:0] d;
   logic              busy;
   logic              done;
   logic [MANT_W:0]   quot;
   logic              exact;

   integer seed;

   // Vector table, expected columns filled from the integer reference
   logic [MANT_W-1:0] tab_n [$];
   logic [MANT_W-1:0] tab_d [$];
   logic [MANT_W:0]   tab_q [$];
   logic              tab_x [$];

   gdiv_top #(
      .MANT_W (MANT_W)
   ) u_dut (
      .clk   (clk),
      .reset (reset),
      .start (start),
      .n     (n),
      .d     (d),
      .busy  (busy),
      .done  (done),
      .quot  (quot),
      .exact (exact)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   ////////////////////////////////////////
   // Reference model and checks
   ////////////////////////////////////////

   // floor(n * 2^MANT_W / d) in 64-bit arithmetic
   function automatic logic [MANT_W:0] expected_quot(input logic [MANT_W-1:0] nn,
                                                      input logic [MANT_W-1:0] dd);
      longint unsigned num;
      num = 64'(nn) << MANT_W;
      return (MANT_W+1)'(num / 64'(dd));
   endfunction

   function automatic logic expected_exact(input logic [MANT_W-1:0] nn,
                                           input logic [MANT_W-1:0] dd);
      longint unsigned num;
      num = 64'(nn) << MANT_W;
      return ((num % 64'(dd)) == 0);
   endfunction

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check_quot(input logic [MANT_W:0] got, input logic [MANT_W:0] exp,
                             input string ctx);
      if (got !== exp)
         report_failure($sformatf("[ERROR] quot got 0x%0h expected 0x%0h (%s)", got, exp, ctx));
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp,
                             input string ctx);
      if (got !== exp)
         report_failure($sformatf("[ERROR] %s got 0x%0h expected 0x%0h (%s)",
                                  name, got, exp, ctx));
   endtask

   task automatic check_latency(input int got, input int exp, input string ctx);
      if (got != exp)
         report_failure($sformatf("[ERROR] done latency got 0x%0h expected 0x%0h cycles (%s)",
                                  got, exp, ctx));
   endtask

   task automatic add_vector(input logic [MANT_W-1:0] nn, input logic [MANT_W-1:0] dd);
      tab_n.push_back(nn);
      tab_d.push_back(dd);
      tab_q.push_back(expected_quot(nn, dd));
      tab_x.push_back(expected_exact(nn, dd));
   endtask

   ////////////////////////////////////////
   // One division with all its checks
   ////////////////////////////////////////

   // Starts in the cycle after the previous done, ends at the negedge of done
   task automatic divide_and_check(input logic [MANT_W-1:0] nn, input logic [MANT_W-1:0] dd,
                                   input logic [MANT_W:0] exp_q, input logic exp_x,
                                   input logic poke_busy);
      int    cycles;
      string ctx;
      ctx = $sformatf("n 0x%0h d 0x%0h", nn, dd);
      @(negedge clk);
      // Previous done lasted a single cycle
      check_flag("done", done, 1'b0, ctx);
      check_flag("busy", busy, 1'b0, ctx);
      n     = nn;
      d     = dd;
      start = 1'b1;
      @(negedge clk);
      cycles = 1;
      start  = 1'b0;
      // Different operands on the bus, only the accepted start samples them
      n = {1'b1, ~nn[MANT_W-2:0]};
      d = {1'b1, ~dd[MANT_W-2:0]};
      check_flag("busy", busy, 1'b1, ctx);
      while (done !== 1'b1) begin
         if (cycles > LATENCY + 4)
            report_failure($sformatf("done never arrived after start (%s)", ctx));
         // Extra start while busy must be dropped
         start = poke_busy && (cycles == 3);
         @(negedge clk);
         cycles++;
      end
      start = 1'b0;
      check_latency(cycles, LATENCY, ctx);
      check_quot(quot, exp_q, ctx);
      check_flag("exact", exact, exp_x, ctx);
   endtask

   // Ends the run if the tests stall
   initial begin
      #(WATCHDOG_NS);
      report_failure("watchdog expired before the tests finished");
   end

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////

   initial begin
      logic [31:0]       r;
      logic [MANT_W-1:0] rn;
      logic [MANT_W-1:0] rd;
      seed        = 32'h56ac;
      reset       = 1'b1;
      start       = 1'b0;
      n           = '0;
      d           = '0;
      repeat (10) @(negedge clk);
      reset = 1'b0;

      // Outputs after reset, quiet without a start
      @(negedge clk);
      check_flag("busy", busy, 1'b0, "after reset");
      check_flag("done", done, 1'b0, "after reset");
      check_quot(quot, '0, "after reset");
      check_flag("exact", exact, 1'b0, "after reset");
      repeat (8) begin
         @(negedge clk);
         check_flag("done", done, 1'b0, "idle without start");
      end

      // Equal operands give 2^MANT_W
      add_vector(24'h800000, 24'h800000);
      add_vector(24'hFFFFFF, 24'hFFFFFF);
      add_vector(24'hABCDEF, 24'hABCDEF);
      // Extreme ratios
      add_vector(24'h800000, 24'hFFFFFF);
      add_vector(24'hFFFFFF, 24'h800000);
      // Exact quotients, 3d/2 and friends
      add_vector(24'hC00000, 24'h800000);
      add_vector(24'hF00000, 24'hA00000);
      add_vector(24'hD80000, 24'h900000);
      add_vector(24'h900000, 24'hC00000);
      // Divisors on both sides of seed interval edges
      add_vector(24'hC00000, 24'h80FFFF);
      add_vector(24'hC00000, 24'h810000);
      add_vector(24'hFFFFFF, 24'hBFFFFF);
      add_vector(24'hFFFFFF, 24'hC00000);
      add_vector(24'h876543, 24'hFEFFFF);
      add_vector(24'h876543, 24'hFF0000);
      add_vector(24'hFFFFFF, 24'h817FFF);

      for (int i = 0; i < tab_n.size(); i++) begin
         divide_and_check(tab_n[i], tab_d[i], tab_q[i], tab_x[i], 1'b0);
      end

      // Start while busy is ignored, one done only
      divide_and_check(24'hC00000, 24'h800000, expected_quot(24'hC00000, 24'h800000),
                       expected_exact(24'hC00000, 24'h800000), 1'b1);
      repeat (LATENCY + 4) begin
         @(negedge clk);
         check_flag("done", done, 1'b0, "after ignored start");
      end

      // Seeded random normalized pairs, back to back
      for (int k = 0; k < N_RAND; k++) begin
         r  = $random(seed);
         rn = {1'b1, r[MANT_W-2:0]};
         r  = $random(seed);
         rd = {1'b1, r[MANT_W-2:0]};
         divide_and_check(rn, rd, expected_quot(rn, rd), expected_exact(rn, rd), 1'b0);
      end

      @(negedge clk);
      $display("TEST PASSED");
      $finish;
   end

endmodule

//--- compile.f
common/gdiv_pkg.sv
hw/gdiv/recip_seed.sv
hw/gdiv/gdiv_conv_pipe.sv
hw/gdiv/gdiv_control.sv
hw/gdiv/gdiv_correct.sv
hw/gdiv_top.sv
bench/gdiv_tb.sv

//--- Makefile
# Verilator build and run for the Goldschmidt divider testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module gdiv_tb -Mdir obj_dir -f compile.f
	-./obj_dir/Vgdiv_tb > $(LOG) 2>&1
	@if grep -q "TEST PASSED" $(LOG); then \
		echo "simulation passed, see $(LOG)"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
